// File: odt_pkg.sv
// shared widths and rate constants for the ODT timing slice
// quarter-rate word type, decoded both as one flat vector and per phase
// type of the pulse extension amount

package odt_pkg;

	// ranks served by this slice, one ODT bit per rank in every phase
	localparam int RANK_COUNT = 2;

	// memory-clock phases carried by one controller clock (quarter rate)
	localparam int RATE_MULT = 4;

	// one controller-clock word holds every rank bit of every phase
	localparam int WORD_WIDTH = RANK_COUNT * RATE_MULT;

	// width of a phase index within one quarter-rate word
	localparam int PHASE_SEL_WIDTH = $clog2(RATE_MULT);

	// the quarter-rate ODT word
	// flat is used by the OR network and the pins, phase by anything that indexes a phase
	// phase 0 is the earliest memory-clock phase and sits in the low bits of flat
	typedef union packed {
		logic [WORD_WIDTH-1:0] flat;
		logic [RATE_MULT-1:0][RANK_COUNT-1:0] phase;
	} phase_word_u;

	// number of extra phases a pulse is stretched by, 0 to 3
	// three is the most that fits, since the window reaches back at most one word
	typedef logic [1:0] extend_t;

endpackage

// File: odt_cmd_decoder.sv
// write command decoder for the ODT slice
// turns a one-cycle command strobe into a single-phase ODT pulse per selected rank
// the pulse word is registered, so it follows the strobe by one controller cycle

module odt_cmd_decoder (
	input  logic                                clk,
	input  logic                                reset_n,
	input  logic                                cmd_valid,
	input  logic [odt_pkg::PHASE_SEL_WIDTH-1:0] cmd_phase,
	input  logic [odt_pkg::RANK_COUNT-1:0]      cmd_rank_mask,
	output odt_pkg::phase_word_u                pulse_word
);

	// next value of the pulse word, built through the per-phase view
	odt_pkg::phase_word_u pulse_next;

	// every phase stays low except the one the command points at
	// several ranks may be selected at once, each gets its own bit in that phase
	always_comb
	begin
		pulse_next.flat = '0;
		if (cmd_valid)
		begin
			// the rank mask lands in exactly one phase slice
			pulse_next.phase[cmd_phase] = cmd_rank_mask;
		end
	end

	// one register stage between the command strobe and the pulse word
	// cycles without a strobe load an all-zero word, so the pulse lasts one cycle
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			// ODT idles low, nothing is pending out of reset
			pulse_word.flat <= '0;
		end
		else
		begin
			pulse_word <= pulse_next;
		end
	end

	// a strobe with an unknown phase or mask would place X into the pulse word
	// and from there into every stretched phase downstream
	a_cmd_known : assert property (
		@(posedge clk) disable iff (!reset_n)
		cmd_valid |-> !$isunknown({cmd_phase, cmd_rank_mask})
	)
	else
	begin
		$error("odt_cmd_decoder: command phase or rank mask unknown while cmd_valid is high");
	end

endmodule

// File: odt_cycle_extender.sv
// quarter-rate ODT pulse extender
// keeps the previous pulse word and ORs each phase with up to three earlier phases
// pulses stretch by 0 to 3 memory-clock phases, also across the controller cycle boundary

module odt_cycle_extender (
	input  logic                 clk,
	input  logic                 reset_n,
	input  odt_pkg::extend_t     extend_by,
	input  odt_pkg::phase_word_u pulse_word,
	output odt_pkg::phase_word_u stretched_word
);

	// pulse word of the previous controller cycle
	odt_pkg::phase_word_u prev_word;

	// the eight most recent phases in time order
	// positions 0 to 3 hold the previous word, positions 4 to 7 the current one
	logic [2*odt_pkg::RATE_MULT-1:0][odt_pkg::RANK_COUNT-1:0] window;

	// the held word only feeds the early positions of the window
	// it clears to zero, so the first word after reset sees no earlier pulses
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			prev_word.flat <= '0;
		end
		else
		begin
			prev_word <= pulse_word;
		end
	end

	// the older word goes in the low half, so window index follows time
	assign window = {pulse_word.flat, prev_word.flat};

	// output phase p is the OR of window positions RATE_MULT+p-k for k = 0 .. extend_by
	// with extend_by at 0 the word passes unchanged
	// with a larger extend_by the low phases reach back into the previous word
	always_comb
	begin
		stretched_word.flat = '0;
		for (int p = 0; p < odt_pkg::RATE_MULT; p++)
		begin
			for (int k = 0; k < odt_pkg::RATE_MULT; k++)
			begin
				// k = 0 is the phase itself, each further k one phase earlier
				if (k <= int'(extend_by))
				begin
					stretched_word.phase[p] = stretched_word.phase[p]
						| window[odt_pkg::RATE_MULT + p - k];
				end
			end
		end
	end

	// stretching only ever adds ODT time, it never removes a requested phase
	a_pulse_kept : assert property (
		@(posedge clk) disable iff (!reset_n)
		(pulse_word.flat & ~stretched_word.flat) == '0
	)
	else
	begin
		$error("odt_cycle_extender: a pulse bit was lost in the stretched word");
	end

endmodule

// File: odt_edge_stage.sv
// pin register stage for the ODT word
// registers the stretched word and marks per phase and rank where ODT turns on and off
// phase 3 of the registered word is the predecessor of the new phase 0

module odt_edge_stage (
	input  logic                 clk,
	input  logic                 reset_n,
	input  odt_pkg::phase_word_u stretched_word,
	output odt_pkg::phase_word_u odt_word,
	output odt_pkg::phase_word_u odt_on,
	output odt_pkg::phase_word_u odt_off
);

	// for every phase, the value of the phase just before it in time
	odt_pkg::phase_word_u last_word;

	// phases 1 to 3 look at the phase below them in the same word
	// phase 0 looks back at phase 3 of the word that is on the pins now
	always_comb
	begin
		last_word.flat = {
			stretched_word.flat[odt_pkg::WORD_WIDTH-odt_pkg::RANK_COUNT-1:0],
			odt_word.phase[odt_pkg::RATE_MULT-1]
		};
	end

	// all outputs come straight from flops
	// after reset the pins idle low, so the first word's predecessor counts as low too
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			odt_word.flat <= '0;
			odt_on.flat   <= '0;
			odt_off.flat  <= '0;
		end
		else
		begin
			odt_word <= stretched_word;
			// rising edge, high now and low one phase earlier
			odt_on.flat <= stretched_word.flat & ~last_word.flat;
			// falling edge, low now and high one phase earlier
			odt_off.flat <= last_word.flat & ~stretched_word.flat;
		end
	end

	// one rank cannot turn on and off in the same phase
	a_edges_exclusive : assert property (
		@(posedge clk) disable iff (!reset_n)
		(odt_on.flat & odt_off.flat) == '0
	)
	else
	begin
		$error("odt_edge_stage: on and off edge set for the same phase and rank");
	end

endmodule

// File: odt_extend_top.sv
// top level of the quarter-rate ODT timing slice
// command decoder, then pulse extender, then pin and edge register stage
// a command sampled at one edge reaches the outputs two cycles later

module odt_extend_top (
	input  logic                                clk,
	input  logic                                reset_n,
	input  logic                                cmd_valid,
	input  logic [odt_pkg::PHASE_SEL_WIDTH-1:0] cmd_phase,
	input  logic [odt_pkg::RANK_COUNT-1:0]      cmd_rank_mask,
	input  odt_pkg::extend_t                    extend_by,
	output odt_pkg::phase_word_u                odt_word,
	output odt_pkg::phase_word_u                odt_on,
	output odt_pkg::phase_word_u                odt_off
);

	// single-phase pulses, one cycle after the command
	odt_pkg::phase_word_u pulse_word;

	// pulses after stretching, same cycle as pulse_word
	odt_pkg::phase_word_u stretched_word;

	odt_cmd_decoder u_cmd_decoder (
		.clk           (clk),
		.reset_n       (reset_n),
		.cmd_valid     (cmd_valid),
		.cmd_phase     (cmd_phase),
		.cmd_rank_mask (cmd_rank_mask),
		.pulse_word    (pulse_word)
	);

	// extend_by is a level, it takes effect on the word registered at the next edge
	odt_cycle_extender u_cycle_extender (
		.clk            (clk),
		.reset_n        (reset_n),
		.extend_by      (extend_by),
		.pulse_word     (pulse_word),
		.stretched_word (stretched_word)
	);

	odt_edge_stage u_edge_stage (
		.clk            (clk),
		.reset_n        (reset_n),
		.stretched_word (stretched_word),
		.odt_word       (odt_word),
		.odt_on         (odt_on),
		.odt_off        (odt_off)
	);

endmodule

// File: tb_odt_extend.sv
// testbench for the quarter-rate ODT timing slice
// reads stimulus and expected words from the golden file and drives the DUT
// expected words sit in a two-deep queue until the DUT pipeline delivers them
// compare tasks for the pin word and for the on and off edge pair

module tb_odt_extend;

	timeunit 1ns;
	timeprecision 1ps;

	// reset length and the limits of each wait loop, in clock cycles
	localparam int RESET_CYCLES = 10;
	localparam int RESET_TIMEOUT = 40;
	localparam int DRAIN_TIMEOUT = 10;

	// cycles from a command line to the outputs it produces
	localparam int PIPE_DEPTH = 2;

	logic                                clk;
	logic                                reset_n;
	logic                                cmd_valid;
	logic [odt_pkg::PHASE_SEL_WIDTH-1:0] cmd_phase;
	logic [odt_pkg::RANK_COUNT-1:0]      cmd_rank_mask;
	odt_pkg::extend_t                    extend_by;
	odt_pkg::phase_word_u                odt_word;
	odt_pkg::phase_word_u                odt_on;
	odt_pkg::phase_word_u                odt_off;

	int word_errors;
	int edge_errors;
	int other_errors;

	// expected results in line order, oldest at the front
	string                exp_name_q[$];
	odt_pkg::phase_word_u exp_word_q[$];
	odt_pkg::phase_word_u exp_on_q[$];
	odt_pkg::phase_word_u exp_off_q[$];

	odt_extend_top DUT (
		.clk           (clk),
		.reset_n       (reset_n),
		.cmd_valid     (cmd_valid),
		.cmd_phase     (cmd_phase),
		.cmd_rank_mask (cmd_rank_mask),
		.extend_by     (extend_by),
		.odt_word      (odt_word),
		.odt_on        (odt_on),
		.odt_off       (odt_off)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	// every DUT input starts idle, reset is released on a rising edge
	initial
	begin
		reset_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_phase = '0;
		cmd_rank_mask = '0;
		extend_by = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;
	end

	task automatic check_word(input string name, input odt_pkg::phase_word_u expected,
		input odt_pkg::phase_word_u actual);
		if (actual.flat !== expected.flat)
		begin
			$display("[FAIL] %s odt_word: expected %h, actual %h", name, expected.flat,
				actual.flat);
			word_errors++;
		end
	endtask

	// on and off are checked as one pair, since they come from the same phase comparison
	task automatic check_edges(input string name, input odt_pkg::phase_word_u exp_on,
		input odt_pkg::phase_word_u exp_off, input odt_pkg::phase_word_u act_on,
		input odt_pkg::phase_word_u act_off);
		if (act_on.flat !== exp_on.flat || act_off.flat !== exp_off.flat)
		begin
			$display("[FAIL] %s odt_on/odt_off: expected %h/%h, actual %h/%h", name,
				exp_on.flat, exp_off.flat, act_on.flat, act_off.flat);
			edge_errors++;
		end
	endtask

	// outputs must sit at zero while nothing has come through the pipeline yet
	task automatic check_idle(input string name);
		odt_pkg::phase_word_u zero;
		zero.flat = '0;
		check_word(name, zero, odt_word);
		check_edges(name, zero, zero, odt_on, odt_off);
	endtask

	// compares the oldest queued expectation with what is on the outputs now
	task automatic compare_oldest();
		string                name;
		odt_pkg::phase_word_u word;
		odt_pkg::phase_word_u on_word;
		odt_pkg::phase_word_u off_word;
		name = exp_name_q.pop_front();
		word = exp_word_q.pop_front();
		on_word = exp_on_q.pop_front();
		off_word = exp_off_q.pop_front();
		check_word(name, word, odt_word);
		check_edges(name, on_word, off_word, odt_on, odt_off);
	endtask

	task automatic finish_run();
		$display("errors: odt_word %0d, odt_on/odt_off %0d, other %0d", word_errors,
			edge_errors, other_errors);
		if (word_errors + edge_errors + other_errors == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	initial
	begin
		int                   fd;
		int                   code;
		int                   cycles;
		bit                   done;
		string                name;
		string                rest;
		logic                 v_valid;
		logic [1:0]           v_phase;
		logic [1:0]           v_mask;
		logic [1:0]           v_ext;
		logic [7:0]           v_word;
		logic [7:0]           v_on;
		logic [7:0]           v_off;
		odt_pkg::phase_word_u w;

		word_errors = 0;
		edge_errors = 0;
		other_errors = 0;
		done = 1'b0;

		// outputs are checked at falling edges, half a cycle away from any update
		cycles = 0;
		while (reset_n !== 1'b1 && cycles < RESET_TIMEOUT)
		begin
			@(negedge clk);
			check_idle("reset");
			cycles++;
		end

		if (reset_n !== 1'b1)
		begin
			$display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
			other_errors++;
		end
		else
		begin
			fd = $fopen("odt_golden.txt", "r");
			if (fd == 0)
			begin
				$display("could not open the golden file odt_golden.txt");
				other_errors++;
			end
			else
			begin
				while (!done)
				begin
					code = $fscanf(fd, "%s", name);
					if (code != 1)
					begin
						// nothing left to read
						done = 1'b1;
					end
					else if (name[0] == "#")
					begin
						code = $fgets(rest, fd);
					end
					else
					begin
						code = $fscanf(fd, "%h %h %h %h %h %h %h", v_valid, v_phase, v_mask,
							v_ext, v_word, v_on, v_off);
						if (code != 7)
						begin
							$display("golden line %s is incomplete, only %0d fields read",
								name, code);
							other_errors++;
							done = 1'b1;
						end
						else
						begin
							@(posedge clk);
							cmd_valid <= v_valid;
							cmd_phase <= v_phase;
							cmd_rank_mask <= v_mask;
							extend_by <= v_ext;
							exp_name_q.push_back(name);
							w.flat = v_word;
							exp_word_q.push_back(w);
							w.flat = v_on;
							exp_on_q.push_back(w);
							w.flat = v_off;
							exp_off_q.push_back(w);
							@(negedge clk);
							// the first two lines after reset still see an empty pipeline
							if (exp_name_q.size() > PIPE_DEPTH)
							begin
								compare_oldest();
							end
							else
							begin
								check_idle("reset_exit");
							end
						end
					end
				end
				$fclose(fd);

				// idle commands while the last expectations come due
				cycles = 0;
				while (exp_name_q.size() > 0 && cycles < DRAIN_TIMEOUT)
				begin
					@(posedge clk);
					cmd_valid <= 1'b0;
					@(negedge clk);
					compare_oldest();
					cycles++;
				end
				if (exp_name_q.size() > 0)
				begin
					$display("%0d expected results were never compared", exp_name_q.size());
					other_errors++;
				end
			end
		end

		finish_run();
	end

endmodule

// File: odt_golden.txt
# test cmd_valid cmd_phase cmd_rank_mask extend_by exp_odt_word exp_odt_on exp_odt_off, all hex
# expected words appear two cycles after the line is driven, word bit = phase * 2 + rank
idle_0        0 0 0 0 00 00 00
idle_1        0 0 0 0 00 00 00
zx_p0_m1      1 0 1 0 01 01 04
zx_p1_m2      1 1 2 0 08 08 20
zx_p2_m3      1 2 3 0 30 30 c0
zx_p3_m1      1 3 1 0 40 40 00
zx_p0_m2      1 0 2 0 02 02 09
zx_p1_m3      1 1 3 0 0c 0c 30
zx_p2_m1      1 2 1 0 10 10 40
zx_p3_m2      1 3 2 0 80 80 00
zx_p0_m3      1 0 3 0 03 01 0c
zx_p1_m1      1 1 1 0 04 04 10
zx_p2_m2      1 2 2 0 20 20 80
zx_p3_m3      1 3 3 0 c0 c0 00
zx_tail       0 0 0 0 00 00 03
zx_gap        0 0 0 0 00 00 00
ext1_p0_m1    1 0 1 1 05 01 10
ext1_gap      0 0 0 1 00 00 00
ext2_p0_m2    1 0 2 2 2a 02 80
ext2_gap      0 0 0 2 00 00 00
ext3_p0_m3    1 0 3 3 ff 03 00
ext3_tail     0 0 0 3 00 00 03
wrap_p3_m1    1 3 1 3 40 40 00
wrap_next     0 0 0 3 15 00 40
wrap_gap      0 0 0 3 00 00 00
b2b_p2_m3     1 2 3 2 f0 30 00
b2b_p1_m1     1 1 1 2 57 00 08
b2b_p0_m3     1 0 3 2 3f 02 c0
b2b_tail      0 0 0 2 00 00 00
b2b_gap       0 0 0 2 00 00 00

// File: Makefile
# Verilator lint, simulation and clean for the ODT timing slice

VERILATOR  ?= verilator
TOP        := tb_odt_extend
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_TEXT  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
odt_pkg.sv
odt_cmd_decoder.sv
odt_cycle_extender.sv
odt_edge_stage.sv
odt_extend_top.sv
tb_odt_extend.sv
